//--- hw/clint_pkg.sv
////////////////////////////////////////////////////////////////////////////
// CLINT shared definitions
// Bus and time widths, register map and reset values
////////////////////////////////////////////////////////////////////////////

package clint_pkg;

    // Bus and timer widths, fixed for a 32-bit hart
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int TIME_W = 64;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [TIME_W-1:0] time_t;

    ////////////////////////////////////////////////////////////////////////
    // Register map, one 32-bit word per offset
    ////////////////////////////////////////////////////////////////////////

    localparam addr_t MSIP_OFFSET        = 16'h0000;
    localparam addr_t MTIME_LO_OFFSET    = 16'h0008;
    localparam addr_t MTIME_HI_OFFSET    = 16'h000C;
    localparam addr_t MTIMECMP_LO_OFFSET = 16'h0010;
    localparam addr_t MTIMECMP_HI_OFFSET = 16'h0014;

    // Depth of the rtc synchronizer chain
    localparam int SYNC_STAGES = 2;

    // Compare value out of reach so the timer interrupt stays low
    localparam time_t MTIMECMP_RESET = {TIME_W{1'b1}};

endpackage

//--- hw/rtc_tick_sync.sv
////////////////////////////////////////////////////////////////////////////
// RTC tick synchronizer
// Brings rtc into the aclk domain and emits a one-cycle pulse per rise
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rtc_tick_sync import clint_pkg::*; (
    input  logic aclk,
    input  logic aresetn,
    input  logic srst,
    input  logic rtc,
    output logic tick
);

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   prev_q;
    logic                   rtc_s;

    // Last stage of the chain is the usable level
    assign rtc_s = sync_q[SYNC_STAGES-1];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sync_q <= '0;
            prev_q <= 1'b0;
            tick   <= 1'b0;
        end else if (srst) begin
            sync_q <= '0;
            prev_q <= 1'b0;
            tick   <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], rtc};
            prev_q <= rtc_s;
            // Rising edge only, so the rtc duty cycle does not matter
            tick   <= rtc_s & ~prev_q;
        end
    end

endmodule

//--- hw/clint_timer.sv
////////////////////////////////////////////////////////////////////////////
// CLINT timer
// mtime counter and mtimecmp register with byte-strobed word writes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clint_timer import clint_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       srst,
    input  logic       tick,
    input  logic [1:0] mtime_we,
    input  logic [1:0] mtimecmp_we,
    input  data_t      wdata,
    input  strb_t      strb,
    output time_t      mtime,
    output time_t      mtimecmp,
    output logic       timer_irq
);

    time_t mtime_nxt;
    time_t mtimecmp_nxt;

    // Replace only the byte lanes whose strobe is set
    function automatic data_t merge_bytes(input data_t old_word,
                                          input data_t new_word,
                                          input strb_t lanes);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (lanes[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Next-state logic
    ////////////////////////////////////////////////////////////////////////

    // A bus write to either mtime half takes priority over the tick
    always_comb begin
        mtime_nxt = mtime;
        if (|mtime_we) begin
            if (mtime_we[0]) begin
                mtime_nxt[0 +: DATA_W] = merge_bytes(mtime[0 +: DATA_W], wdata, strb);
            end
            if (mtime_we[1]) begin
                mtime_nxt[DATA_W +: DATA_W] = merge_bytes(mtime[DATA_W +: DATA_W],
                                                          wdata, strb);
            end
        end else if (tick) begin
            mtime_nxt = mtime + time_t'(1);
        end
    end

    always_comb begin
        mtimecmp_nxt = mtimecmp;
        if (mtimecmp_we[0]) begin
            mtimecmp_nxt[0 +: DATA_W] = merge_bytes(mtimecmp[0 +: DATA_W], wdata, strb);
        end
        if (mtimecmp_we[1]) begin
            mtimecmp_nxt[DATA_W +: DATA_W] = merge_bytes(mtimecmp[DATA_W +: DATA_W],
                                                         wdata, strb);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Registers and comparator
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mtime     <= '0;
            mtimecmp  <= MTIMECMP_RESET;
            timer_irq <= 1'b0;
        end else if (srst) begin
            mtime     <= '0;
            mtimecmp  <= MTIMECMP_RESET;
            timer_irq <= 1'b0;
        end else begin
            mtime     <= mtime_nxt;
            mtimecmp  <= mtimecmp_nxt;
            // Level interrupt, one cycle behind the register contents
            timer_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

//--- hw/clint_regs.sv
////////////////////////////////////////////////////////////////////////////
// CLINT register slave
// APB-style decode, ready pulse, MSIP bit and registered read data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clint_regs import clint_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       srst,
    // Bus slave
    input  logic       slv_en,
    input  logic       slv_wr,
    input  addr_t      slv_addr,
    input  data_t      slv_wdata,
    input  strb_t      slv_strb,
    output data_t      slv_rdata,
    output logic       slv_ready,
    // Timer side
    input  time_t      mtime,
    input  time_t      mtimecmp,
    output logic [1:0] mtime_we,
    output logic [1:0] mtimecmp_we,
    output data_t      wdata,
    output strb_t      strb,
    // Software interrupt
    output logic       sw_irq
);

    logic  wr_en;
    logic  rd_en;
    logic  hit_msip;
    logic  hit_mtime_lo;
    logic  hit_mtime_hi;
    logic  hit_mtimecmp_lo;
    logic  hit_mtimecmp_hi;
    data_t rdata_mux;

    ////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////

    // Accesses are performed on every enable cycle, not only the first
    assign wr_en = slv_en & slv_wr;
    assign rd_en = slv_en & ~slv_wr;

    assign hit_msip        = (slv_addr == MSIP_OFFSET);
    assign hit_mtime_lo    = (slv_addr == MTIME_LO_OFFSET);
    assign hit_mtime_hi    = (slv_addr == MTIME_HI_OFFSET);
    assign hit_mtimecmp_lo = (slv_addr == MTIMECMP_LO_OFFSET);
    assign hit_mtimecmp_hi = (slv_addr == MTIMECMP_HI_OFFSET);

    // Write enables toward the timer, bit 0 selects the low word
    assign mtime_we    = {wr_en & hit_mtime_hi, wr_en & hit_mtime_lo};
    assign mtimecmp_we = {wr_en & hit_mtimecmp_hi, wr_en & hit_mtimecmp_lo};

    // Data and strobes are shared by both timer registers
    assign wdata = slv_wdata;
    assign strb  = slv_strb;

    ////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (slv_addr)
            MSIP_OFFSET: begin
                rdata_mux = {{(DATA_W-1){1'b0}}, sw_irq};
            end
            MTIME_LO_OFFSET: begin
                rdata_mux = mtime[0 +: DATA_W];
            end
            MTIME_HI_OFFSET: begin
                rdata_mux = mtime[DATA_W +: DATA_W];
            end
            MTIMECMP_LO_OFFSET: begin
                rdata_mux = mtimecmp[0 +: DATA_W];
            end
            MTIMECMP_HI_OFFSET: begin
                rdata_mux = mtimecmp[DATA_W +: DATA_W];
            end
            // Unmapped space reads as zero
            default: begin
                rdata_mux = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Handshake, read data and MSIP
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            slv_ready <= 1'b0;
            slv_rdata <= '0;
            sw_irq    <= 1'b0;
        end else if (srst) begin
            slv_ready <= 1'b0;
            slv_rdata <= '0;
            sw_irq    <= 1'b0;
        end else begin
            // One-cycle pulse, two cycles per transfer
            slv_ready <= slv_en & ~slv_ready;

            // Read data holds once the transfer ends
            if (rd_en) begin
                slv_rdata <= rdata_mux;
            end

            if (wr_en && hit_msip && slv_strb[0]) begin
                sw_irq <= slv_wdata[0];
            end
        end
    end

endmodule

//--- hw/clint_top.sv
////////////////////////////////////////////////////////////////////////////
// CLINT top level
// Joins the rtc synchronizer, the timer and the register slave
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clint_top import clint_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  srst,
    // Bus slave
    input  logic  slv_en,
    input  logic  slv_wr,
    input  addr_t slv_addr,
    input  data_t slv_wdata,
    input  strb_t slv_strb,
    output data_t slv_rdata,
    output logic  slv_ready,
    // Real-time clock and interrupts
    input  logic  rtc,
    output logic  sw_irq,
    output logic  timer_irq
);

    logic       tick;
    logic [1:0] mtime_we;
    logic [1:0] mtimecmp_we;
    data_t      wdata;
    strb_t      strb;
    time_t      mtime;
    time_t      mtimecmp;

    rtc_tick_sync u_sync (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .rtc     (rtc),
        .tick    (tick)
    );

    clint_timer u_timer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .tick        (tick),
        .mtime_we    (mtime_we),
        .mtimecmp_we (mtimecmp_we),
        .wdata       (wdata),
        .strb        (strb),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .timer_irq   (timer_irq)
    );

    clint_regs u_regs (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .slv_en      (slv_en),
        .slv_wr      (slv_wr),
        .slv_addr    (slv_addr),
        .slv_wdata   (slv_wdata),
        .slv_strb    (slv_strb),
        .slv_rdata   (slv_rdata),
        .slv_ready   (slv_ready),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .mtime_we    (mtime_we),
        .mtimecmp_we (mtimecmp_we),
        .wdata       (wdata),
        .strb        (strb),
        .sw_irq      (sw_irq)
    );

endmodule

//--- verif/clint_checker.sv
////////////////////////////////////////////////////////////////////////////
// CLINT checker
// Concurrent assertions on the bus ready strobe and the interrupt lines
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clint_checker (
    input logic aclk,
    input logic aresetn,
    input logic srst,
    input logic slv_en,
    input logic slv_ready,
    input logic sw_irq,
    input logic timer_irq
);

    // Number of failed assertions, summed into the closing report
    int unsigned fail_cnt = 0;

    // Ready is a one-cycle pulse
    ready_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        slv_ready |=> !slv_ready)
    else begin
        $error("slv_ready high in two consecutive cycles");
        fail_cnt++;
    end

    ready_cause: assert property (@(posedge aclk) disable iff (!aresetn)
        slv_ready |-> $past(slv_en) && !$past(slv_ready))
    else begin
        $error("slv_ready rose without a preceding enable cycle");
        fail_cnt++;
    end

    // Outputs held low in reset and right after a soft reset
    reset_quiet: assert property (@(posedge aclk)
        (!aresetn || $past(srst)) |-> !slv_ready && !sw_irq && !timer_irq)
    else begin
        $error("ready or interrupt high during or right after reset");
        fail_cnt++;
    end

    irq_known: assert property (@(posedge aclk) disable iff (!aresetn)
        !$isunknown(timer_irq))
    else begin
        $error("timer_irq unknown after reset");
        fail_cnt++;
    end

endmodule

bind clint_top clint_checker chk0 (.*);

//--- verif/clint_tb.sv
////////////////////////////////////////////////////////////////////////////
// CLINT testbench
// Bus sequences and rtc pulses checked against a model of the registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clint_tb import clint_pkg::*; ();

    logic  aclk;
    logic  aresetn;
    logic  srst;
    logic  slv_en;
    logic  slv_wr;
    addr_t slv_addr;
    data_t slv_wdata;
    strb_t slv_strb;
    data_t slv_rdata;
    logic  slv_ready;
    logic  rtc;
    logic  sw_irq;
    logic  timer_irq;

    // Model of the register contents
    logic  msip_m;
    time_t mtime_m;
    time_t mtimecmp_m;

    int unsigned mismatches;
    int unsigned timeouts;

    addr_t reg_map [5] = '{MSIP_OFFSET, MTIME_LO_OFFSET, MTIME_HI_OFFSET,
                           MTIMECMP_LO_OFFSET, MTIMECMP_HI_OFFSET};
    addr_t unmapped [3] = '{16'h0004, 16'h0018, 16'h0100};

    clint_top dut0 (.*);

    always #2 aclk = ~aclk;

    task automatic compare(input string name, input data_t exp, input data_t act);
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    function automatic data_t model_word(input addr_t addr);
        case (addr)
            MSIP_OFFSET:        return data_t'(msip_m);
            MTIME_LO_OFFSET:    return mtime_m[31:0];
            MTIME_HI_OFFSET:    return mtime_m[63:32];
            MTIMECMP_LO_OFFSET: return mtimecmp_m[31:0];
            MTIMECMP_HI_OFFSET: return mtimecmp_m[63:32];
            default:            return '0;
        endcase
    endfunction

    // One transfer, enable held until the ready pulse
    task automatic bus_xfer(input logic write, input addr_t addr, input data_t data,
                            input strb_t lanes, output data_t rdata);
        int cyc;
        @(posedge aclk);
        slv_en    <= 1'b1;
        slv_wr    <= write;
        slv_addr  <= addr;
        slv_wdata <= data;
        slv_strb  <= lanes;
        cyc = 0;
        do begin
            @(posedge aclk);
            cyc++;
        end while (!slv_ready && cyc < 20);
        rdata = slv_rdata;
        slv_en <= 1'b0;
        if (!slv_ready) begin
            $display("Transfer at address %h got no ready within 20 cycles", addr);
            timeouts++;
        end
    endtask

    // Bus write, then the same byte-lane merge applied to the model
    task automatic write_reg(input addr_t addr, input data_t data, input strb_t lanes);
        data_t discard;
        data_t mask;
        data_t merged;
        bus_xfer(1'b1, addr, data, lanes, discard);
        mask   = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        merged = (model_word(addr) & ~mask) | (data & mask);
        case (addr)
            MSIP_OFFSET:        msip_m            = merged[0];
            MTIME_LO_OFFSET:    mtime_m[31:0]     = merged;
            MTIME_HI_OFFSET:    mtime_m[63:32]    = merged;
            MTIMECMP_LO_OFFSET: mtimecmp_m[31:0]  = merged;
            MTIMECMP_HI_OFFSET: mtimecmp_m[63:32] = merged;
            default: ;
        endcase
    endtask

    task automatic read_check(input addr_t addr);
        data_t got;
        bus_xfer(1'b0, addr, '0, '0, got);
        compare($sformatf("slv_rdata[%h]", addr), model_word(addr), got);
    endtask

    task automatic check_all_regs();
        foreach (reg_map[i]) begin
            read_check(reg_map[i]);
        end
    endtask

    // High for 1 to 4 cycles, low for 3 to 5
    task automatic rtc_pulse();
        int hi_cycles;
        hi_cycles = 1 + $urandom % 4;
        @(posedge aclk);
        rtc <= 1'b1;
        repeat (hi_cycles) @(posedge aclk);
        rtc <= 1'b0;
        repeat (3 + $urandom % 3) @(posedge aclk);
    endtask

    initial begin
        time_t cmp;
        int    n;
        void'($urandom(32'h1995));
        aclk       = 1'b0;
        aresetn    = 1'b0;
        srst       = 1'b0;
        slv_en     = 1'b0;
        slv_wr     = 1'b0;
        slv_addr   = '0;
        slv_wdata  = '0;
        slv_strb   = '0;
        rtc        = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        msip_m     = 1'b0;
        mtime_m    = '0;
        mtimecmp_m = MTIMECMP_RESET;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        check_all_regs();

        ////////////////////////////////////////////////////////////////////
        // MSIP and strobed timer words, rtc idle
        ////////////////////////////////////////////////////////////////////

        for (int i = 0; i < 8; i++) begin
            write_reg(MSIP_OFFSET, $urandom, strb_t'($urandom));
            compare("sw_irq", data_t'(msip_m), data_t'(sw_irq));
            read_check(MSIP_OFFSET);
        end
        for (int i = 0; i < 12; i++) begin
            n = 1 + $urandom % 4;
            write_reg(reg_map[n], $urandom, strb_t'($urandom));
            read_check(reg_map[n]);
        end

        // Tick counting, low word kept clear of a carry
        write_reg(MTIME_LO_OFFSET, $urandom % 32'hFFFF_FFF0, 4'hF);
        write_reg(MTIME_HI_OFFSET, $urandom, 4'hF);
        n = 3 + $urandom % 6;
        repeat (n) rtc_pulse();
        repeat (5) @(posedge aclk);
        mtime_m = mtime_m + time_t'(n);
        read_check(MTIME_LO_OFFSET);
        read_check(MTIME_HI_OFFSET);

        ////////////////////////////////////////////////////////////////////
        // Timer interrupt
        ////////////////////////////////////////////////////////////////////

        cmp = mtime_m + 64'd3;
        write_reg(MTIMECMP_LO_OFFSET, cmp[31:0], 4'hF);
        write_reg(MTIMECMP_HI_OFFSET, cmp[63:32], 4'hF);
        read_check(MTIMECMP_LO_OFFSET);
        read_check(MTIMECMP_HI_OFFSET);
        compare("timer_irq", 32'h0, data_t'(timer_irq));
        repeat (3) rtc_pulse();
        repeat (5) @(posedge aclk);
        mtime_m = mtime_m + 64'd3;
        compare("timer_irq", 32'h1, data_t'(timer_irq));
        write_reg(MTIMECMP_LO_OFFSET, 32'hFFFF_FFFF, 4'hF);
        write_reg(MTIMECMP_HI_OFFSET, 32'hFFFF_FFFF, 4'hF);
        repeat (3) @(posedge aclk);
        compare("timer_irq", 32'h0, data_t'(timer_irq));

        // Unmapped space reads zero and ignores writes
        foreach (unmapped[i]) begin
            read_check(unmapped[i]);
            write_reg(unmapped[i], $urandom, 4'hF);
            check_all_regs();
        end

        // Soft reset with both interrupts raised
        write_reg(MSIP_OFFSET, 32'h1, 4'h1);
        write_reg(MTIMECMP_LO_OFFSET, 32'h0, 4'hF);
        write_reg(MTIMECMP_HI_OFFSET, 32'h0, 4'hF);
        repeat (3) @(posedge aclk);
        compare("sw_irq", 32'h1, data_t'(sw_irq));
        compare("timer_irq", 32'h1, data_t'(timer_irq));
        srst <= 1'b1;
        @(posedge aclk);
        srst <= 1'b0;
        @(posedge aclk);
        compare("sw_irq", 32'h0, data_t'(sw_irq));
        compare("timer_irq", 32'h0, data_t'(timer_irq));
        msip_m     = 1'b0;
        mtime_m    = '0;
        mtimecmp_m = MTIMECMP_RESET;
        check_all_regs();

        $display("Errors: %0d mismatches, %0d bus timeouts, %0d assertion failures",
                 mismatches, timeouts, dut0.chk0.fail_cnt);
        if (mismatches == 0 && timeouts == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
hw/clint_pkg.sv
hw/rtc_tick_sync.sv
hw/clint_timer.sv
hw/clint_regs.sv
hw/clint_top.sv
verif/clint_checker.sv
verif/clint_tb.sv

//--- Makefile
# Verilator build and run of the CLINT testbench

SRCS := $(shell cat project.f)

obj_dir/Vclint_tb: project.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module clint_tb \
		--Mdir obj_dir -f project.f

.PHONY: run clean

run: obj_dir/Vclint_tb
	./obj_dir/Vclint_tb +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	elif ! grep -q "Simulation passed" sim.log; then \
		echo "Run ended without a result line, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
